//--- include/rrag_config.svh
`ifndef RRAG_CONFIG_SVH
`define RRAG_CONFIG_SVH

`define RRAG_NUM_GPR 8  // eax through edi
`define RRAG_NUM_SEG 8
`define RRAG_REG_AW  3
`define RRAG_DATA_W  32
`define RRAG_SEG_W   16  // selector lands in the upper half of the linear base

`endif

//--- src/rrag_pkg.sv
`include "rrag_config.svh"

package rrag_pkg;

    typedef logic [`RRAG_REG_AW-1:0] reg_addr_t;
    typedef logic [`RRAG_DATA_W-1:0] word_t;
    typedef logic [`RRAG_SEG_W-1:0]  sel_t;

    // byte count of an operand is 1 << code
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2,
        SIZE_QWORD = 2'd3
    } opsize_t;

    typedef logic [1:0] scale_t;  // index is shifted left by this amount

    typedef enum logic {
        ADDR_16 = 1'b0,
        ADDR_32 = 1'b1
    } addr_mode_t;

    // offset from the start address to the operand's last byte
    function automatic word_t last_byte_offset(opsize_t size);
        word_t one;
        one = word_t'(1);
        return (one << size) - one;
    endfunction

endpackage

//--- src/rrag_stage_if.sv
`timescale 1ns/10ps

interface rrag_stage_if import rrag_pkg::*; ();

    logic       valid;      // one cycle per instruction
    word_t      base_val;   // already zero when the base is unused
    word_t      index_val;  // already zero when the index is unused
    sel_t       seg_val;
    scale_t     scale;
    word_t      disp;
    opsize_t    opsize;
    addr_mode_t addr_mode;

    modport src (
        output valid,
        output base_val,
        output index_val,
        output seg_val,
        output scale,
        output disp,
        output opsize,
        output addr_mode
    );

    modport dst (
        input valid,
        input base_val,
        input index_val,
        input seg_val,
        input scale,
        input disp,
        input opsize,
        input addr_mode
    );

endinterface

//--- src/gpr_file.sv
`timescale 1ns/10ps
`include "rrag_config.svh"

module gpr_file import rrag_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    output logic      rd_pend_a,
    output logic      rd_pend_b,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      set_en,
    input  reg_addr_t set_addr
);

    word_t                    regs [`RRAG_NUM_GPR];
    logic [`RRAG_NUM_GPR-1:0] pend;  // result still in flight for this register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // the set comes last so a new producer overrides a retiring one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= '0;
        end else begin
            if (wb_en) begin
                pend[wb_addr] <= 1'b0;
            end
            if (set_en) begin
                pend[set_addr] <= 1'b1;
            end
        end
    end

    // a same-cycle read still sees pending because the write port has no bypass
    always_comb begin
        rd_data_a = regs[rd_addr_a];
        rd_data_b = regs[rd_addr_b];
        rd_pend_a = pend[rd_addr_a];
        rd_pend_b = pend[rd_addr_b];
    end

endmodule

//--- src/seg_file.sv
`timescale 1ns/10ps
`include "rrag_config.svh"

module seg_file import rrag_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rd_addr,
    output sel_t      rd_sel,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  sel_t      wb_data
);

    sel_t sels [`RRAG_NUM_SEG];  // es, cs, ss, ds, fs, gs and two spare slots

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_SEG; i++) begin
                sels[i] <= '0;
            end
        end else if (wb_en) begin
            sels[wb_addr] <= wb_data;
        end
    end

    assign rd_sel = sels[rd_addr];  // segments carry no pending state

endmodule

//--- src/reg_read.sv
`timescale 1ns/10ps

module reg_read import rrag_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid_in,
    input  logic       use_base,
    input  logic       use_index,
    input  logic       dest_valid,
    input  reg_addr_t  base_addr,
    input  reg_addr_t  index_addr,
    input  reg_addr_t  seg_addr,
    input  reg_addr_t  dest_addr,
    input  scale_t     scale,
    input  word_t      disp,
    input  opsize_t    opsize,
    input  addr_mode_t addr_mode,
    output logic       stall,
    output reg_addr_t  gpr_rd_addr_a,
    output reg_addr_t  gpr_rd_addr_b,
    input  word_t      gpr_rd_data_a,
    input  word_t      gpr_rd_data_b,
    input  logic       gpr_rd_pend_a,
    input  logic       gpr_rd_pend_b,
    output reg_addr_t  seg_rd_addr,
    input  sel_t       seg_rd_sel,
    output logic       set_en,
    output reg_addr_t  set_addr,
    rrag_stage_if.src  out
);

    logic accept;

    assign gpr_rd_addr_a = base_addr;  // port a serves the base
    assign gpr_rd_addr_b = index_addr;
    assign seg_rd_addr   = seg_addr;

    // an unused source never holds the instruction back
    assign stall  = valid_in & ((use_base & gpr_rd_pend_a) | (use_index & gpr_rd_pend_b));
    assign accept = valid_in & ~stall;

    assign set_en   = accept & dest_valid;  // file marks the destination on the accept edge
    assign set_addr = dest_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out.base_val  <= use_base ? gpr_rd_data_a : '0;
            out.index_val <= use_index ? gpr_rd_data_b : '0;
            out.seg_val   <= seg_rd_sel;
            out.scale     <= scale;
            out.disp      <= disp;
            out.opsize    <= opsize;
            out.addr_mode <= addr_mode;
        end
    end

endmodule

//--- src/addr_gen.sv
`timescale 1ns/10ps
`include "rrag_config.svh"

module addr_gen import rrag_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    rrag_stage_if.dst in,
    output logic      valid_out,
    output word_t     mem_addr,
    output word_t     mem_addr_end
);

    localparam int LOW_W = `RRAG_DATA_W - `RRAG_SEG_W;

    word_t sum_off;
    word_t offset;
    word_t seg_base;
    word_t start_c;
    word_t end_c;

    always_comb begin
        sum_off = in.base_val + (in.index_val << in.scale) + in.disp;
        // 16-bit addressing wraps the effective address inside the segment
        if (in.addr_mode == ADDR_16) begin
            offset = {{`RRAG_SEG_W{1'b0}}, sum_off[LOW_W-1:0]};
        end else begin
            offset = sum_off;
        end
        seg_base = {in.seg_val, {LOW_W{1'b0}}};  // selector times 65536
        start_c  = seg_base + offset;
        end_c    = start_c + last_byte_offset(in.opsize);  // may wrap past the top
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            mem_addr     <= start_c;
            mem_addr_end <= end_c;
        end
    end

endmodule

//--- src/rrag.sv
`timescale 1ns/10ps

module rrag import rrag_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid_in,
    input  logic       use_base,
    input  logic       use_index,
    input  logic       dest_valid,
    input  reg_addr_t  base_addr,
    input  reg_addr_t  index_addr,
    input  reg_addr_t  seg_addr,
    input  reg_addr_t  dest_addr,
    input  scale_t     scale,
    input  word_t      disp,
    input  opsize_t    opsize,
    input  addr_mode_t addr_mode,
    input  logic       wb_en,
    input  reg_addr_t  wb_addr,
    input  word_t      wb_data,
    input  logic       seg_wb_en,
    input  reg_addr_t  seg_wb_addr,
    input  sel_t       seg_wb_data,
    output logic       stall,
    output logic       valid_out,
    output word_t      mem_addr,
    output word_t      mem_addr_end
);

    reg_addr_t rd_addr_a, rd_addr_b, seg_rd_addr, set_addr;
    word_t     rd_data_a, rd_data_b;
    logic      rd_pend_a, rd_pend_b, set_en;
    sel_t      seg_rd_sel;

    rrag_stage_if stage ();

    gpr_file u_gpr (
        .clk(clk), .rst_n(rst_n),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_pend_a(rd_pend_a), .rd_pend_b(rd_pend_b),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .set_en(set_en), .set_addr(set_addr)
    );

    seg_file u_seg (
        .clk(clk), .rst_n(rst_n),
        .rd_addr(seg_rd_addr), .rd_sel(seg_rd_sel),
        .wb_en(seg_wb_en), .wb_addr(seg_wb_addr), .wb_data(seg_wb_data)
    );

    reg_read u_read (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in),
        .use_base(use_base), .use_index(use_index), .dest_valid(dest_valid),
        .base_addr(base_addr), .index_addr(index_addr),
        .seg_addr(seg_addr), .dest_addr(dest_addr),
        .scale(scale), .disp(disp), .opsize(opsize), .addr_mode(addr_mode),
        .stall(stall),
        .gpr_rd_addr_a(rd_addr_a), .gpr_rd_addr_b(rd_addr_b),
        .gpr_rd_data_a(rd_data_a), .gpr_rd_data_b(rd_data_b),
        .gpr_rd_pend_a(rd_pend_a), .gpr_rd_pend_b(rd_pend_b),
        .seg_rd_addr(seg_rd_addr), .seg_rd_sel(seg_rd_sel),
        .set_en(set_en), .set_addr(set_addr),
        .out(stage.src)
    );

    addr_gen u_agen (
        .clk(clk), .rst_n(rst_n), .in(stage.dst),
        .valid_out(valid_out), .mem_addr(mem_addr), .mem_addr_end(mem_addr_end)
    );

endmodule

//--- tests/rrag_tb.sv
`timescale 1ns/10ps

module rrag_tb import rrag_pkg::*; ();

    typedef struct packed {
        logic       v, ub, ui, dv;
        reg_addr_t  b, x, s, d;
        scale_t     sc;
        opsize_t    sz;
        addr_mode_t am;
        word_t      disp;
        logic       wb;
        reg_addr_t  wa;
        word_t      wd;
        logic       swb;
        reg_addr_t  swa;
        sel_t       swd;
        logic       stall;  // expected stall in this cycle
    } row_t;

    logic clk, rst_n, valid_in, use_base, use_index, dest_valid;
    reg_addr_t base_addr, index_addr, seg_addr, dest_addr, wb_addr, seg_wb_addr;
    scale_t scale;
    word_t disp, wb_data, mem_addr, mem_addr_end;
    opsize_t opsize;
    addr_mode_t addr_mode;
    logic wb_en, seg_wb_en, stall, valid_out;
    sel_t seg_wb_data;

    row_t  rows [64];
    int    num_rows = 0;
    logic  table_ready = 1'b0;
    word_t m_regs [8];
    sel_t  m_sels [8];
    logic [7:0] m_pend;

    rrag dut0 (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in),
        .use_base(use_base), .use_index(use_index), .dest_valid(dest_valid),
        .base_addr(base_addr), .index_addr(index_addr),
        .seg_addr(seg_addr), .dest_addr(dest_addr),
        .scale(scale), .disp(disp), .opsize(opsize), .addr_mode(addr_mode),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .seg_wb_en(seg_wb_en), .seg_wb_addr(seg_wb_addr), .seg_wb_data(seg_wb_data),
        .stall(stall), .valid_out(valid_out),
        .mem_addr(mem_addr), .mem_addr_end(mem_addr_end)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(string name, word_t exp, word_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    function automatic word_t byte_count(opsize_t sz);
        case (sz)
            SIZE_BYTE:  return 32'd1;
            SIZE_WORD:  return 32'd2;
            SIZE_DWORD: return 32'd4;
            default:    return 32'd8;
        endcase
    endfunction

    function automatic word_t expect_start(word_t base, word_t index, scale_t sc, word_t dsp,
                                           sel_t sel, addr_mode_t am);
        word_t off;
        off = base + (index << sc) + dsp;
        if (am == ADDR_16) begin
            off = off & 32'h0000_ffff;  // effective address wraps inside the segment
        end
        return {sel, 16'h0000} + off;
    endfunction

    function automatic row_t issue(logic ub, logic ui, logic dv, reg_addr_t b, reg_addr_t x,
                                   reg_addr_t s, reg_addr_t d, scale_t sc, opsize_t sz,
                                   addr_mode_t am, word_t dsp, logic st);
        row_t r;
        r = '0;
        r.v = 1'b1;
        r.ub = ub;
        r.ui = ui;
        r.dv = dv;
        r.b = b;
        r.x = x;
        r.s = s;
        r.d = d;
        r.sc = sc;
        r.sz = sz;
        r.am = am;
        r.disp = dsp;
        r.stall = st;
        return r;
    endfunction

    function automatic row_t with_wb(row_t r, reg_addr_t a, word_t d);
        r.wb = 1'b1;
        r.wa = a;
        r.wd = d;
        return r;
    endfunction

    function automatic row_t with_seg(row_t r, reg_addr_t a, sel_t d);
        r.swb = 1'b1;
        r.swa = a;
        r.swd = d;
        return r;
    endfunction

    task automatic put_row(row_t r);
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        row_t hz;
        put_row('0);
        put_row(with_wb(issue(0, 0, 0, 0, 0, 0, 0, 0, SIZE_DWORD, ADDR_32, $urandom, 0),
                        0, $urandom));
        put_row(with_seg(with_wb('0, 1, $urandom), 1, sel_t'($urandom)));
        put_row(with_seg(with_wb('0, 2, $urandom), 2, 16'hffff));
        for (int k = 3; k < 8; k++) begin
            put_row(with_wb('0, reg_addr_t'(k), $urandom));
        end
        put_row(issue(1, 1, 0, 1, 2, 1, 0, 0, SIZE_DWORD, ADDR_32, $urandom, 0));
        put_row(issue(1, 1, 0, 3, 4, 1, 0, 1, SIZE_WORD, ADDR_32, $urandom, 0));
        put_row(issue(1, 1, 0, 5, 6, 0, 0, 2, SIZE_BYTE, ADDR_32, $urandom, 0));
        put_row(issue(1, 1, 0, 7, 0, 3, 0, 3, SIZE_QWORD, ADDR_32, $urandom, 0));
        put_row(issue(0, 1, 0, 0, 1, 1, 0, 2, SIZE_DWORD, ADDR_32, $urandom, 0));
        put_row(issue(1, 0, 0, 2, 0, 1, 0, 0, SIZE_DWORD, ADDR_32, $urandom, 0));
        put_row(issue(1, 1, 0, 3, 4, 1, 0, 1, SIZE_WORD, ADDR_16, 32'h0000_fff0, 0));
        put_row(issue(0, 0, 0, 0, 0, 1, 0, 0, SIZE_BYTE, ADDR_16, 32'h0001_2345, 0));
        put_row(issue(0, 0, 0, 0, 0, 2, 0, 0, SIZE_QWORD, ADDR_32, 32'h0000_fffe, 0));
        put_row(issue(0, 0, 0, 0, 0, 2, 0, 0, SIZE_WORD, ADDR_32, 32'h0000_ffff, 0));
        // r5 gets a producer, then a reader waits for its writeback
        put_row(issue(0, 0, 1, 0, 0, 0, 5, 0, SIZE_DWORD, ADDR_32, $urandom, 0));
        hz = issue(1, 1, 0, 5, 1, 0, 0, 1, SIZE_DWORD, ADDR_32, $urandom, 1);
        put_row(hz);
        put_row(with_wb(hz, 5, 32'h1234_5678));
        hz.stall = 1'b0;
        put_row(hz);
        // set and clear of r6 on one edge leaves it pending
        put_row(with_wb(issue(0, 0, 1, 0, 0, 0, 6, 0, SIZE_BYTE, ADDR_32, $urandom, 0),
                        6, $urandom));
        hz = issue(1, 0, 0, 6, 0, 0, 0, 0, SIZE_WORD, ADDR_32, $urandom, 1);
        put_row(hz);
        put_row(with_wb(hz, 6, $urandom));
        hz.stall = 1'b0;
        put_row(hz);
        put_row(with_seg(issue(1, 1, 0, 1, 2, 1, 0, 2, SIZE_DWORD, ADDR_32, $urandom, 0),
                         1, sel_t'($urandom)));
        put_row(issue(1, 0, 0, 3, 0, 1, 0, 0, SIZE_WORD, ADDR_32, $urandom, 0));
        put_row(with_seg(issue(1, 1, 0, 2, 3, 2, 0, 3, SIZE_QWORD, ADDR_32, $urandom, 0),
                         2, sel_t'($urandom)));
        put_row('0);
    endtask

    task automatic drive_row(row_t r);
        valid_in = r.v;
        use_base = r.ub;
        use_index = r.ui;
        dest_valid = r.dv;
        base_addr = r.b;
        index_addr = r.x;
        seg_addr = r.s;
        dest_addr = r.d;
        scale = r.sc;
        opsize = r.sz;
        addr_mode = r.am;
        disp = r.disp;
        wb_en = r.wb;
        wb_addr = r.wa;
        wb_data = r.wd;
        seg_wb_en = r.swb;
        seg_wb_addr = r.swa;
        seg_wb_data = r.swd;
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((num_rows + 20) * 4);
        fail_run("watchdog expired, the run did not finish in time");
    end

    initial begin : main
        row_t  cur;
        logic  acc, m_stall, s1_v, s2_v, ent_v;
        word_t s1_a, s1_e, s2_a, s2_e, ent_a, ent_e, base_v, index_v;
        int unsigned seed;
        seed = $urandom(32'he18b_afd3);
        rst_n = 1'b0;
        drive_row('0);
        build_table();
        table_ready = 1'b1;
        for (int k = 0; k < 8; k++) begin
            m_regs[k] = '0;
            m_sels[k] = '0;
        end
        m_pend = '0;
        cur = '0;
        acc = 1'b0;
        {s1_v, s2_v, ent_v} = '0;
        {s1_a, s1_e, s2_a, s2_e, ent_a, ent_e} = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int c = 0; c < num_rows + 3; c++) begin
            @(posedge clk);
            // the edge just taken applied the previous row
            if (cur.wb) begin
                m_regs[cur.wa] = cur.wd;
                m_pend[cur.wa] = 1'b0;
            end
            if (acc && cur.dv) begin
                m_pend[cur.d] = 1'b1;  // a new producer beats the retiring one
            end
            if (cur.swb) begin
                m_sels[cur.swa] = cur.swd;
            end
            {s2_v, s2_a, s2_e} = {s1_v, s1_a, s1_e};
            {s1_v, s1_a, s1_e} = {ent_v, ent_a, ent_e};
            #1;
            check_flag("valid_out", s2_v, valid_out);
            if (s2_v) begin
                check_addr("mem_addr", s2_a, mem_addr);
                check_addr("mem_addr_end", s2_e, mem_addr_end);
            end
            cur = (c < num_rows) ? rows[c] : row_t'('0);
            drive_row(cur);
            #1;
            m_stall = cur.v && ((cur.ub && m_pend[cur.b]) || (cur.ui && m_pend[cur.x]));
            if (m_stall !== cur.stall) begin
                fail_run($sformatf("stimulus row %0d expects the wrong stall", c));
            end
            check_flag("stall", m_stall, stall);
            acc = cur.v && !m_stall;
            ent_v = acc;
            if (acc) begin
                base_v = cur.ub ? m_regs[cur.b] : '0;
                index_v = cur.ui ? m_regs[cur.x] : '0;
                ent_a = expect_start(base_v, index_v, cur.sc, cur.disp, m_sels[cur.s], cur.am);
                ent_e = ent_a + byte_count(cur.sz) - 32'd1;
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- rrag.f
+incdir+include
src/rrag_pkg.sv
src/rrag_stage_if.sv
src/gpr_file.sv
src/seg_file.sv
src/reg_read.sv
src/addr_gen.sv
src/rrag.sv
tests/rrag_tb.sv

//--- Bender.yml
package:
  name: rrag

export_include_dirs:
  - include

sources:
  - src/rrag_pkg.sv
  - src/rrag_stage_if.sv
  - src/gpr_file.sv
  - src/seg_file.sv
  - src/reg_read.sv
  - src/addr_gen.sv
  - src/rrag.sv
  - target: test
    files:
      - tests/rrag_tb.sv
